// ==== Makefile ====
# Verilator build and run for the dma test node

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dma_test_node_tb
BUILD_DIR ?= obj_dir
FLIST     ?= flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard source/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/dma_test_node_tb.sv ====
// dma test node testbench
// random host traffic and copy jobs checked against a memory model,
// with zero-length jobs, done back-pressure and a watchdog

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module dma_test_node_tb;

  import dma_job_pkg::*;
  import mem_bus_pkg::*;

  localparam int NUM_JOBS    = 8;
  localparam int HOST_MARGIN = 8000;
  // every job may take 256 words x 3 requesters x 4 cycles
  localparam int WATCHDOG_CYCLES = (NUM_JOBS + 1) * 256 * 3 * 4 + HOST_MARGIN;

  logic         clk;
  logic         rst_n;
  logic         job_valid;
  addr_t        job_src;
  addr_t        job_dst;
  len_t         job_len;
  logic         job_ready;
  logic         done_valid;
  done_status_e done_status;
  logic         done_ready;
  logic         ext_req;
  mem_op_e      ext_op;
  addr_t        ext_addr;
  word_t        ext_wdata;
  logic         ext_gnt;
  logic         ext_rvalid;
  word_t        ext_rdata;

  integer seed;
  int     errors;
  word_t  model_mem [`DMA_MEM_WORDS];

  tb_clock_gen tb_clock_gen_inst (
    .clk_o (clk)
  );

  dma_test_node dma_test_node_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .job_valid_i   (job_valid),
    .job_src_i     (job_src),
    .job_dst_i     (job_dst),
    .job_len_i     (job_len),
    .job_ready_o   (job_ready),
    .done_valid_o  (done_valid),
    .done_status_o (done_status),
    .done_ready_i  (done_ready),
    .ext_req_i     (ext_req),
    .ext_op_i      (ext_op),
    .ext_addr_i    (ext_addr),
    .ext_wdata_i   (ext_wdata),
    .ext_gnt_o     (ext_gnt),
    .ext_rvalid_o  (ext_rvalid),
    .ext_rdata_o   (ext_rdata)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  function automatic int pick_below(input int n);
    pick_below = int'({$random(seed)} % n);
  endfunction

  // caller sits on a falling edge, grant is sampled just after it
  task automatic host_write(input int addr, input word_t data);
    ext_req   = 1'b1;
    ext_op    = MEM_WRITE;
    ext_addr  = addr_t'(addr);
    ext_wdata = data;
    #1;
    while (!ext_gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ext_req        = 1'b0;
    model_mem[addr] = data;
  endtask

  task automatic host_read_check(input string name, input int addr);
    ext_req  = 1'b1;
    ext_op   = MEM_READ;
    ext_addr = addr_t'(addr);
    #1;
    while (!ext_gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ext_req = 1'b0;
    // data one cycle after the grant
    check_val({name, " rvalid"}, 32'd1, 32'(ext_rvalid));
    check_val(name, model_mem[addr], ext_rdata);
  endtask

  task automatic start_job(input int src, input int dst, input int len);
    job_valid = 1'b1;
    job_src   = addr_t'(src);
    job_dst   = addr_t'(dst);
    job_len   = len_t'(len);
    #1;
    while (!job_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    job_valid = 1'b0;
  endtask

  task automatic wait_done();
    while (!done_valid) begin
      @(negedge clk);
    end
  endtask

  // hold off the response for a while, then take it
  task automatic take_done(input string name, input done_status_e exp_status);
    int hold;
    hold = pick_below(6);
    check_val({name, " status"}, 32'(exp_status), 32'(done_status));
    repeat (hold) begin
      @(negedge clk);
      check_val({name, " held valid"}, 32'd1, 32'(done_valid));
      check_val({name, " held status"}, 32'(exp_status), 32'(done_status));
      check_val({name, " held job_ready"}, 32'd0, 32'(job_ready));
    end
    done_ready = 1'b1;
    @(negedge clk);
    done_ready = 1'b0;
    check_val({name, " released valid"}, 32'd0, 32'(done_valid));
    check_val({name, " released job_ready"}, 32'd1, 32'(job_ready));
  endtask

  // source and destination in opposite halves of the low 192 words
  task automatic run_copy();
    int len;
    int src;
    int dst;
    int tmp;
    int addr;
    len = 1 + pick_below(64);
    src = pick_below(97 - len);
    dst = 96 + pick_below(97 - len);
    if (pick_below(2) == 1) begin
      tmp = src;
      src = dst;
      dst = tmp;
    end
    start_job(src, dst, len);
    // host traffic in the top region while the copy runs
    repeat (3) begin
      addr = 192 + pick_below(64);
      host_write(addr, $random(seed));
      host_read_check("shared host read", addr);
    end
    wait_done();
    take_done("copy", DONE_OK);
    for (int i = 0; i < len; i++) begin
      model_mem[dst + i] = model_mem[src + i];
    end
    for (int i = 0; i < len; i++) begin
      host_read_check("copy readback", dst + i);
    end
  endtask

  task automatic run_zero_len();
    int dst;
    dst = 96 + pick_below(88);
    start_job(pick_below(96), dst, 0);
    // response on the first edge after acceptance
    check_val("zero length timing", 32'd1, 32'(done_valid));
    take_done("zero length", DONE_REJECTED);
    for (int i = 0; i < 8; i++) begin
      host_read_check("zero length readback", dst + i);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int addrs [$];
    seed       = 45;
    errors     = 0;
    rst_n      = 1'b0;
    job_valid  = 1'b0;
    job_src    = '0;
    job_dst    = '0;
    job_len    = '0;
    done_ready = 1'b0;
    ext_req    = 1'b0;
    ext_op     = MEM_READ;
    ext_addr   = '0;
    ext_wdata  = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_val("reset job_ready", 32'd1, 32'(job_ready));
    check_val("reset done_valid", 32'd0, 32'(done_valid));
    check_val("reset ext_gnt", 32'd0, 32'(ext_gnt));
    check_val("reset ext_rvalid", 32'd0, 32'(ext_rvalid));

    // whole bank gets known contents first
    for (int a = 0; a < `DMA_MEM_WORDS; a++) begin
      host_write(a, $random(seed));
    end

    repeat (16) begin
      addrs.push_back(pick_below(`DMA_MEM_WORDS));
      host_write(addrs[$], $random(seed));
    end
    foreach (addrs[i]) begin
      host_read_check("host access", addrs[i]);
    end

    for (int j = 0; j < NUM_JOBS; j++) begin
      run_copy();
    end
    run_zero_len();

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired, a handshake never completed");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// testbench clock
// free-running clock with a 100 ns period

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/dma_job_pkg.sv
source/mem_bus_pkg.sv
source/sram_bank.sv
source/mem_arbiter.sv
source/dma_read_engine.sv
source/dma_write_engine.sv
source/dma_job_ctrl.sv
source/dma_test_node.sv
bench/tb_clock_gen.sv
bench/dma_test_node_tb.sv

// ==== source/dma_job_ctrl.sv ====
// dma job controller
// takes one copy job at a time, refuses zero lengths, starts both
// engines and holds the completion response until it is taken

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module dma_job_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // job request
  input  logic                     job_valid_i,
  input  dma_job_pkg::addr_t       job_src_i,
  input  dma_job_pkg::addr_t       job_dst_i,
  input  dma_job_pkg::len_t        job_len_i,
  output logic                     job_ready_o,
  // completion response
  output logic                     done_valid_o,
  output dma_job_pkg::done_status_e done_status_o,
  input  logic                     done_ready_i,
  // engine start
  output logic                     rd_start_o,
  output dma_job_pkg::addr_t       rd_src_o,
  output dma_job_pkg::len_t        rd_len_o,
  output logic                     wr_start_o,
  output dma_job_pkg::addr_t       wr_dst_o,
  output dma_job_pkg::len_t        wr_len_o,
  input  logic                     wr_done_i
);

  import dma_job_pkg::*;

  ctrl_state_e state_q;
  len_t        job_len_q;
  logic        job_take;
  logic        job_zero;

  assign job_ready_o = (state_q == CTRL_IDLE);
  assign job_take    = job_valid_i && job_ready_o;
  assign job_zero    = (job_len_i == '0);

  // both engines copy the same number of words
  assign rd_len_o = job_len_q;
  assign wr_len_o = job_len_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= CTRL_IDLE;
      done_valid_o <= 1'b0;
      rd_start_o   <= 1'b0;
      wr_start_o   <= 1'b0;
    end else begin
      rd_start_o <= 1'b0;
      wr_start_o <= 1'b0;
      case (state_q)
        CTRL_IDLE: begin
          if (job_take && job_zero) begin
            state_q      <= CTRL_DONE;
            done_valid_o <= 1'b1;
          end else if (job_take) begin
            state_q    <= CTRL_BUSY;
            rd_start_o <= 1'b1;
            wr_start_o <= 1'b1;
          end
        end
        CTRL_BUSY: begin
          if (wr_done_i) begin
            state_q      <= CTRL_DONE;
            done_valid_o <= 1'b1;
          end
        end
        CTRL_DONE: begin
          // response held until the outside takes it
          if (done_ready_i) begin
            state_q      <= CTRL_IDLE;
            done_valid_o <= 1'b0;
          end
        end
        default: begin
          state_q      <= CTRL_IDLE;
          done_valid_o <= 1'b0;
        end
      endcase
    end
  end

  // job fields latched on acceptance
  always_ff @(posedge clk_i) begin
    if (job_take) begin
      rd_src_o      <= job_src_i;
      wr_dst_o      <= job_dst_i;
      job_len_q     <= job_len_i;
      done_status_o <= job_zero ? DONE_REJECTED : DONE_OK;
    end
  end

  // a response only exists between acceptance and hand-off
  a_no_done_in_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == CTRL_IDLE) |-> !done_valid_o
  ) else $error("done_valid_o high while the controller is idle");

endmodule

`default_nettype wire

// ==== source/dma_job_pkg.sv ====
// dma job types
// word, address and length types for a copy job, the completion
// status and the job controller states

`default_nettype none

`include "dma_node_consts.svh"

package dma_job_pkg;

  // one memory word
  typedef logic [`DMA_DATA_W-1:0] word_t;

  // word address into the bank
  typedef logic [`DMA_ADDR_W-1:0] addr_t;

  // job length in words
  typedef logic [`DMA_LEN_W-1:0] len_t;

  // completion status, zero lengths are refused
  typedef enum logic {
    DONE_OK       = 1'b0,
    DONE_REJECTED = 1'b1
  } done_status_e;

  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_BUSY = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/dma_node_consts.svh ====
// dma test node constants
// widths, memory depth and write-buffer depth shared by the
// controller, both engines, the arbiter and the memory bank

`ifndef DMA_NODE_CONSTS_SVH
`define DMA_NODE_CONSTS_SVH

// ----------------------------------------
// data path
// ----------------------------------------

// one memory word
`define DMA_DATA_W 32
// word address, covers the whole bank
`define DMA_ADDR_W 8
`define DMA_MEM_WORDS 256
// job length, 0 to 256 words
`define DMA_LEN_W 9

// ----------------------------------------
// flow control and arbitration
// ----------------------------------------

// write-buffer entries, also the initial credit count
`define DMA_BUF_DEPTH 4
// dma read, dma write, host
`define DMA_NUM_REQ 3

`endif

// ==== source/dma_read_engine.sv ====
// dma read engine
// fetches the source words of a job while write-buffer credits
// remain and hands every returned word to the write engine

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module dma_read_engine (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // job start
  input  logic                 start_i,
  input  dma_job_pkg::addr_t   src_i,
  input  dma_job_pkg::len_t    len_i,
  // credit returned by the write engine
  input  logic                 credit_i,
  // memory bus
  output logic                 mem_req_o,
  output mem_bus_pkg::mem_op_e mem_op_o,
  output dma_job_pkg::addr_t   mem_addr_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  dma_job_pkg::word_t   mem_rdata_i,
  // toward the write engine
  output logic                 data_valid_o,
  output dma_job_pkg::word_t   data_o
);

  import dma_job_pkg::*;
  import mem_bus_pkg::*;

  localparam int CRED_W = $clog2(`DMA_BUF_DEPTH + 1);

  len_t              rem_q;
  addr_t             addr_q;
  logic [CRED_W-1:0] credits_q;
  logic              rd_fire;

  // request held stable, counters only move on a grant
  assign mem_req_o  = (rem_q != '0) && (credits_q != '0);
  assign mem_op_o   = MEM_READ;
  assign mem_addr_o = addr_q;
  assign rd_fire    = mem_req_o && mem_gnt_i;

  // returned words go on without a stage
  assign data_valid_o = mem_rvalid_i;
  assign data_o       = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rem_q     <= '0;
      addr_q    <= '0;
      credits_q <= CRED_W'(`DMA_BUF_DEPTH);
    end else begin
      if (start_i) begin
        rem_q  <= len_i;
        addr_q <= src_i;
      end else if (rd_fire) begin
        rem_q  <= rem_q - len_t'(1);
        addr_q <= addr_q + addr_t'(1);
      end
      // spend on grant, refill on credit, both at once cancel
      case ({rd_fire, credit_i})
        2'b10:   credits_q <= credits_q - CRED_W'(1);
        2'b01:   credits_q <= credits_q + CRED_W'(1);
        default: credits_q <= credits_q;
      endcase
    end
  end

  // write engine never returns more credits than were spent
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= CRED_W'(`DMA_BUF_DEPTH)
  ) else $error("credit count above the write-buffer depth");

endmodule

`default_nettype wire

// ==== source/dma_test_node.sv ====
// dma test node
// copy engine and host port sharing one memory bank through a
// round-robin arbiter

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module dma_test_node (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // job request
  input  logic                      job_valid_i,
  input  dma_job_pkg::addr_t        job_src_i,
  input  dma_job_pkg::addr_t        job_dst_i,
  input  dma_job_pkg::len_t         job_len_i,
  output logic                      job_ready_o,
  // completion response
  output logic                      done_valid_o,
  output dma_job_pkg::done_status_e done_status_o,
  input  logic                      done_ready_i,
  // host memory port
  input  logic                      ext_req_i,
  input  mem_bus_pkg::mem_op_e      ext_op_i,
  input  dma_job_pkg::addr_t        ext_addr_i,
  input  dma_job_pkg::word_t        ext_wdata_i,
  output logic                      ext_gnt_o,
  output logic                      ext_rvalid_o,
  output dma_job_pkg::word_t        ext_rdata_o
);

  import dma_job_pkg::*;
  import mem_bus_pkg::*;

  // ----------------------------------------
  // internal wires
  // ----------------------------------------

  // controller to engines
  logic    rd_start;
  addr_t   rd_src;
  len_t    rd_len;
  logic    wr_start;
  addr_t   wr_dst;
  len_t    wr_len;
  logic    wr_done;

  // credit loop
  logic    credit;
  logic    data_valid;
  word_t   data;

  // engine memory buses
  logic    rd_req;
  mem_op_e rd_op;
  addr_t   rd_addr;
  logic    rd_gnt;
  logic    rd_rvalid;
  logic    wr_req;
  mem_op_e wr_op;
  addr_t   wr_addr;
  word_t   wr_wdata;
  logic    wr_gnt;
  word_t   rdata;

  // bank port
  logic    mem_en;
  logic    mem_we;
  addr_t   mem_addr;
  word_t   mem_wdata;
  word_t   mem_rdata;

  assign ext_rdata_o = rdata;

  // ----------------------------------------
  // job control and copy engines
  // ----------------------------------------

  dma_job_ctrl dma_job_ctrl_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .job_valid_i   (job_valid_i),
    .job_src_i     (job_src_i),
    .job_dst_i     (job_dst_i),
    .job_len_i     (job_len_i),
    .job_ready_o   (job_ready_o),
    .done_valid_o  (done_valid_o),
    .done_status_o (done_status_o),
    .done_ready_i  (done_ready_i),
    .rd_start_o    (rd_start),
    .rd_src_o      (rd_src),
    .rd_len_o      (rd_len),
    .wr_start_o    (wr_start),
    .wr_dst_o      (wr_dst),
    .wr_len_o      (wr_len),
    .wr_done_i     (wr_done)
  );

  dma_read_engine dma_read_engine_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (rd_start),
    .src_i        (rd_src),
    .len_i        (rd_len),
    .credit_i     (credit),
    .mem_req_o    (rd_req),
    .mem_op_o     (rd_op),
    .mem_addr_o   (rd_addr),
    .mem_gnt_i    (rd_gnt),
    .mem_rvalid_i (rd_rvalid),
    .mem_rdata_i  (rdata),
    .data_valid_o (data_valid),
    .data_o       (data)
  );

  dma_write_engine dma_write_engine_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (wr_start),
    .dst_i        (wr_dst),
    .len_i        (wr_len),
    .data_valid_i (data_valid),
    .data_i       (data),
    .credit_o     (credit),
    .mem_req_o    (wr_req),
    .mem_op_o     (wr_op),
    .mem_addr_o   (wr_addr),
    .mem_wdata_o  (wr_wdata),
    .mem_gnt_i    (wr_gnt),
    .done_o       (wr_done)
  );

  // ----------------------------------------
  // shared memory
  // ----------------------------------------

  // read engine never writes, its write data is tied off
  mem_arbiter mem_arbiter_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_req_i     (rd_req),
    .rd_op_i      (rd_op),
    .rd_addr_i    (rd_addr),
    .rd_wdata_i   (word_t'(0)),
    .rd_gnt_o     (rd_gnt),
    .wr_req_i     (wr_req),
    .wr_op_i      (wr_op),
    .wr_addr_i    (wr_addr),
    .wr_wdata_i   (wr_wdata),
    .wr_gnt_o     (wr_gnt),
    .ext_req_i    (ext_req_i),
    .ext_op_i     (ext_op_i),
    .ext_addr_i   (ext_addr_i),
    .ext_wdata_i  (ext_wdata_i),
    .ext_gnt_o    (ext_gnt_o),
    .rd_rvalid_o  (rd_rvalid),
    .ext_rvalid_o (ext_rvalid_o),
    .rdata_o      (rdata),
    .mem_en_o     (mem_en),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata)
  );

  sram_bank sram_bank_inst (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== source/dma_write_engine.sv ====
// dma write engine
// buffers the words of the read engine, stores them at the job's
// destination, returns one credit per write and flags the last one

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module dma_write_engine (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // job start
  input  logic                 start_i,
  input  dma_job_pkg::addr_t   dst_i,
  input  dma_job_pkg::len_t    len_i,
  // from the read engine
  input  logic                 data_valid_i,
  input  dma_job_pkg::word_t   data_i,
  output logic                 credit_o,
  // memory bus
  output logic                 mem_req_o,
  output mem_bus_pkg::mem_op_e mem_op_o,
  output dma_job_pkg::addr_t   mem_addr_o,
  output dma_job_pkg::word_t   mem_wdata_o,
  input  logic                 mem_gnt_i,
  // end of job
  output logic                 done_o
);

  import dma_job_pkg::*;
  import mem_bus_pkg::*;

  localparam int PTR_W = $clog2(`DMA_BUF_DEPTH);
  localparam int CNT_W = $clog2(`DMA_BUF_DEPTH + 1);

  // ----------------------------------------
  // word buffer
  // ----------------------------------------

  word_t             buf_mem [`DMA_BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              buf_full;
  logic              wr_fire;

  assign buf_full = (count_q == CNT_W'(`DMA_BUF_DEPTH));
  assign wr_fire  = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i) begin
    if (data_valid_i) begin
      buf_mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (data_valid_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (wr_fire) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({data_valid_i, wr_fire})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------
  // destination writes
  // ----------------------------------------

  len_t  rem_q;
  addr_t addr_q;

  // head word goes out as soon as the buffer holds one
  assign mem_req_o   = (count_q != '0);
  assign mem_op_o    = MEM_WRITE;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = buf_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rem_q    <= '0;
      addr_q   <= '0;
      credit_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      credit_o <= wr_fire;
      done_o   <= wr_fire && (rem_q == len_t'(1));
      if (start_i) begin
        rem_q  <= len_i;
        addr_q <= dst_i;
      end else if (wr_fire) begin
        rem_q  <= rem_q - len_t'(1);
        addr_q <= addr_q + addr_t'(1);
      end
    end
  end

  // credit loop in the read engine keeps a full buffer from seeing data
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    data_valid_i |-> !buf_full
  ) else $error("word pushed into a full write buffer");

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
// memory arbiter
// grants one of the three requesters per cycle in round-robin order
// and steers the read data of a granted read back one cycle later

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // dma read requester
  input  logic                 rd_req_i,
  input  mem_bus_pkg::mem_op_e rd_op_i,
  input  dma_job_pkg::addr_t   rd_addr_i,
  input  dma_job_pkg::word_t   rd_wdata_i,
  output logic                 rd_gnt_o,
  // dma write requester
  input  logic                 wr_req_i,
  input  mem_bus_pkg::mem_op_e wr_op_i,
  input  dma_job_pkg::addr_t   wr_addr_i,
  input  dma_job_pkg::word_t   wr_wdata_i,
  output logic                 wr_gnt_o,
  // host requester
  input  logic                 ext_req_i,
  input  mem_bus_pkg::mem_op_e ext_op_i,
  input  dma_job_pkg::addr_t   ext_addr_i,
  input  dma_job_pkg::word_t   ext_wdata_i,
  output logic                 ext_gnt_o,
  // read return, data shared by both readers
  output logic                 rd_rvalid_o,
  output logic                 ext_rvalid_o,
  output dma_job_pkg::word_t   rdata_o,
  // memory side
  output logic                 mem_en_o,
  output logic                 mem_we_o,
  output dma_job_pkg::addr_t   mem_addr_o,
  output dma_job_pkg::word_t   mem_wdata_o,
  input  dma_job_pkg::word_t   mem_rdata_i
);

  import dma_job_pkg::*;
  import mem_bus_pkg::*;

  logic [`DMA_NUM_REQ-1:0] req_vec;
  logic [`DMA_NUM_REQ-1:0] gnt_vec;
  requester_e              last_q;
  requester_e              win;
  mem_op_e                 sel_op;
  addr_t                   sel_addr;
  word_t                   sel_wdata;
  logic                    rd_pend_q;
  logic                    ext_pend_q;

  assign req_vec[REQ_DMA_RD] = rd_req_i;
  assign req_vec[REQ_DMA_WR] = wr_req_i;
  assign req_vec[REQ_EXT]    = ext_req_i;

  // first requester after the last winner
  always_comb begin
    int idx;
    gnt_vec = '0;
    win     = last_q;
    for (int i = 1; i <= `DMA_NUM_REQ; i++) begin
      idx = (int'(last_q) + i) % `DMA_NUM_REQ;
      if (gnt_vec == '0 && req_vec[idx]) begin
        gnt_vec[idx] = 1'b1;
        win          = requester_e'(idx);
      end
    end
  end

  always_comb begin
    case (win)
      REQ_DMA_RD: begin
        sel_op    = rd_op_i;
        sel_addr  = rd_addr_i;
        sel_wdata = rd_wdata_i;
      end
      REQ_DMA_WR: begin
        sel_op    = wr_op_i;
        sel_addr  = wr_addr_i;
        sel_wdata = wr_wdata_i;
      end
      default: begin
        sel_op    = ext_op_i;
        sel_addr  = ext_addr_i;
        sel_wdata = ext_wdata_i;
      end
    endcase
  end

  assign rd_gnt_o    = gnt_vec[REQ_DMA_RD];
  assign wr_gnt_o    = gnt_vec[REQ_DMA_WR];
  assign ext_gnt_o   = gnt_vec[REQ_EXT];
  assign mem_en_o    = |gnt_vec;
  assign mem_we_o    = mem_en_o && (sel_op == MEM_WRITE);
  assign mem_addr_o  = sel_addr;
  assign mem_wdata_o = sel_wdata;

  // bank answers reads one cycle later
  assign rd_rvalid_o  = rd_pend_q;
  assign ext_rvalid_o = ext_pend_q;
  assign rdata_o      = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // dma read wins first after reset
      last_q     <= REQ_EXT;
      rd_pend_q  <= 1'b0;
      ext_pend_q <= 1'b0;
    end else begin
      if (mem_en_o) begin
        last_q <= win;
      end
      rd_pend_q  <= rd_gnt_o && (rd_op_i == MEM_READ);
      ext_pend_q <= ext_gnt_o && (ext_op_i == MEM_READ);
    end
  end

  a_one_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ext_gnt_o, wr_gnt_o, rd_gnt_o})
  ) else $error("more than one requester granted in a cycle");

endmodule

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
// memory bus types
// access opcode and requester ids of the shared bank

`default_nettype none

package mem_bus_pkg;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // value order is the round-robin rotation order
  typedef enum logic [1:0] {
    REQ_DMA_RD = 2'd0,
    REQ_DMA_WR = 2'd1,
    REQ_EXT    = 2'd2
  } requester_e;

endpackage

`default_nettype wire

// ==== source/sram_bank.sv ====
// sram bank
// single-port word memory, writes on the edge, reads with one
// cycle of latency

`timescale 1ns/1ns
`default_nettype none

`include "dma_node_consts.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               en_i,
  input  logic               we_i,
  input  dma_job_pkg::addr_t addr_i,
  input  dma_job_pkg::word_t wdata_i,
  output dma_job_pkg::word_t rdata_o
);

  import dma_job_pkg::*;

  word_t mem [`DMA_MEM_WORDS];

  // read data only changes on a read access
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end else if (en_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire
